/* build.f */
+incdir+dv
hdl/fft_pkg.sv
hdl/pair_demux.sv
hdl/butterfly_lane.sv
hdl/pair_collector.sv
hdl/fft_bfly_top.sv
dv/fft_bfly_tb.sv

/* dv/fft_bfly_ref.svh */
`ifndef FFT_BFLY_REF_SVH
`define FFT_BFLY_REF_SVH

    // ----------------------------------------------------------------------
    // expected output beat
    // ----------------------------------------------------------------------
    typedef struct packed {
        fft_pkg::cplx_t s;                      // expected sample
        logic           second;                 // high for the x1 beat
        logic [31:0]    b_cyc;                  // cycle of b's in_valid
        logic [3:0]     test_id;                // which test queued it
    } exp_t;

    exp_t exp_q[$];                             // x0 then x1, pair after pair
    int   pair_cnt;                             // pairs queued so far

    function automatic logic [15:0] wrap16(input longint v);
        return v[15:0];                         // two's complement wrap
    endfunction

    // x0 = a + b*w, x1 = a - b*w, products truncated by >>> 13
    function automatic fft_pkg::bfly_res_t ref_bfly(input fft_pkg::cplx_t a,
                                                    input fft_pkg::cplx_t b,
                                                    input fft_pkg::twiddle_t w);
        longint             t_re;
        longint             t_im;
        fft_pkg::bfly_res_t r;
        t_re = (longint'($signed(b.re)) * longint'($signed(w.cos))
              - longint'($signed(b.im)) * longint'($signed(w.sin))) >>> 13;
        t_im = (longint'($signed(b.re)) * longint'($signed(w.sin))
              + longint'($signed(b.im)) * longint'($signed(w.cos))) >>> 13;
        t_re = longint'($signed(wrap16(t_re)));   // rotated b back at sample width
        t_im = longint'($signed(wrap16(t_im)));
        r.x0.re = wrap16(longint'($signed(a.re)) + t_re);
        r.x0.im = wrap16(longint'($signed(a.im)) + t_im);
        r.x1.re = wrap16(longint'($signed(a.re)) - t_re);
        r.x1.im = wrap16(longint'($signed(a.im)) - t_im);
        return r;
    endfunction

    task automatic push_pair(input fft_pkg::cplx_t a, input fft_pkg::cplx_t b,
                             input fft_pkg::twiddle_t w, input logic [31:0] b_cyc,
                             input logic [3:0] id);
        fft_pkg::bfly_res_t r;
        exp_t               e;
        r         = ref_bfly(a, b, w);
        e.s       = r.x0;
        e.second  = 1'b0;
        e.b_cyc   = b_cyc;
        e.test_id = id;
        exp_q.push_back(e);
        e.s       = r.x1;
        e.second  = 1'b1;
        exp_q.push_back(e);
        pair_cnt++;
    endtask

`endif

/* dv/fft_bfly_tb.sv */
`timescale 1ns/1ps

module fft_bfly_tb;

    localparam int NUM_LANES = 4;
    localparam int DRAIN_MAX = 200;                 // cycles allowed to empty the queue

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    fft_pkg::cplx_t    in_sample;
    fft_pkg::twiddle_t in_tw;
    logic              out_valid;
    fft_pkg::cplx_t    out_sample;
    logic              out_second;

    logic [31:0]       cyc;                         // free-running cycle count
    logic [3:0]        cur_test;
    int                val_errs;                    // wrong values
    int                other_errs;                  // timeouts, stray pulses
    int                out_cnt;                     // out_valid pulses seen

    `include "fft_bfly_ref.svh"

    fft_bfly_top #(
        .NUM_LANES (NUM_LANES)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .in_tw      (in_tw),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .out_second (out_second)
    );

    always #2 clk = ~clk;                           // 4 ns period

    always @(posedge clk) cyc <= cyc + 1;

    function automatic string test_label(input logic [3:0] id);
        case (id)
            4'd1:    return "identity";
            4'd2:    return "back_to_back";
            4'd3:    return "random_gaps";
            4'd4:    return "extremes";
            default: return "unknown";
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // comparison, one expected beat per out_valid
    // ----------------------------------------------------------------------
    always @(posedge clk) begin : compare
        exp_t        e;
        logic [31:0] lat;
        if (rst_n && out_valid) begin
            out_cnt++;
            if (exp_q.size() == 0) begin
                $display("out_valid pulse at cycle %0d with nothing expected", cyc);
                other_errs++;
            end else begin
                e   = exp_q.pop_front();
                lat = cyc - 1 - e.b_cyc;            // cycles from b's in_valid
                assert (out_sample == e.s) else begin
                    $display("ERR %s: sample expected re=%0d im=%0d, actual re=%0d im=%0d",
                             test_label(e.test_id), e.s.re, e.s.im,
                             out_sample.re, out_sample.im);
                    val_errs++;
                end
                assert (out_second == e.second) else begin
                    $display("ERR %s: out_second expected %0b, actual %0b",
                             test_label(e.test_id), e.second, out_second);
                    val_errs++;
                end
                assert (lat == (e.second ? 32'd8 : 32'd7)) else begin
                    $display("ERR %s: latency expected %0d, actual %0d",
                             test_label(e.test_id), e.second ? 8 : 7, lat);
                    val_errs++;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    function automatic fft_pkg::cplx_t rand_cplx();
        logic [31:0]    r;
        fft_pkg::cplx_t c;
        r    = $urandom();
        c.re = r[15:0];
        c.im = r[31:16];
        return c;
    endfunction

    function automatic fft_pkg::twiddle_t rand_tw();
        logic [31:0]       r;
        fft_pkg::twiddle_t w;
        r     = $urandom();
        w.cos = r[13:0];                            // any Q1.13 value
        w.sin = r[27:14];
        return w;
    endfunction

    task automatic send_sample(input fft_pkg::cplx_t s, input fft_pkg::twiddle_t w);
        @(posedge clk);
        in_valid  <= 1'b1;
        in_sample <= s;
        in_tw     <= w;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // a's twiddle goes out on the bus too, the DUT must drop it
    task automatic send_pair(input fft_pkg::cplx_t a, input fft_pkg::cplx_t b,
                             input fft_pkg::twiddle_t w_a, input fft_pkg::twiddle_t w_b,
                             input int gap_ab, input int gap_after);
        logic [31:0] b_cyc;
        send_sample(a, w_a);
        idle_cycles(gap_ab);
        send_sample(b, w_b);
        b_cyc = cyc;                                // cycle in which b is valid
        push_pair(a, b, w_b, b_cyc, cur_test);
        idle_cycles(gap_after);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_MAX) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected samples never came out", exp_q.size());
            other_errs++;
            exp_q.delete();
        end
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin : main
        fft_pkg::twiddle_t w;
        fft_pkg::cplx_t    a;
        fft_pkg::cplx_t    b;
        logic [15:0]       ext_s [2];
        logic [13:0]       ext_t [2];
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_sample  = '0;
        in_tw      = '0;
        cyc        = '0;
        cur_test   = '0;
        val_errs   = 0;
        other_errs = 0;
        out_cnt    = 0;
        pair_cnt   = 0;
        ext_s[0]   = 16'h7fff;                      // +32767
        ext_s[1]   = 16'h8000;                      // -32768
        ext_t[0]   = 14'h1fff;                      // +8191
        ext_t[1]   = 14'h2000;                      // -8192
        void'($urandom(32'h1912));
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(2);

        cur_test = 4'd1;                            // cos only, then sin only
        for (int i = 0; i < 4; i++) begin
            w.cos = (i < 2) ? 14'd4095 : 14'd0;
            w.sin = (i < 2) ? 14'd0 : 14'd4095;
            send_pair(rand_cplx(), rand_cplx(), rand_tw(), w, 0, 12);
        end
        wait_drain();

        cur_test = 4'd2;                            // in_valid every cycle
        for (int i = 0; i < 24; i++) begin
            send_pair(rand_cplx(), rand_cplx(), rand_tw(), rand_tw(), 0, 0);
        end
        idle_cycles(1);
        wait_drain();

        cur_test = 4'd3;
        for (int i = 0; i < 24; i++) begin
            send_pair(rand_cplx(), rand_cplx(), rand_tw(), rand_tw(),
                      $urandom_range(0, 4), $urandom_range(0, 5));
        end
        idle_cycles(1);
        wait_drain();

        cur_test = 4'd4;                            // corners of both ranges
        for (int k = 0; k < 16; k++) begin
            a.re  = ext_s[k[0]];
            a.im  = ext_s[k[1]];
            b.re  = ext_s[k[2]];
            b.im  = ext_s[~k[0]];
            w.cos = ext_t[k[3]];
            w.sin = ext_t[k[1] ^ k[2]];
            send_pair(a, b, rand_tw(), w, 0, 0);
        end
        idle_cycles(1);
        wait_drain();

        idle_cycles(16);                            // catch any late extra pulse
        assert (out_cnt == 2 * pair_cnt) else begin
            $display("ERR pulse_count: expected %0d, actual %0d", 2 * pair_cnt, out_cnt);
            val_errs++;
        end

        $display("errors: value %0d, other %0d (outputs %0d, pairs %0d)",
                 val_errs, other_errs, out_cnt, pair_cnt);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/butterfly_lane.sv */
`timescale 1ns/1ps

module butterfly_lane (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  fft_pkg::bfly_req_t req,
    output logic               done,
    output fft_pkg::bfly_res_t res
);

    fft_pkg::mul_phase_e                  phase;      // current step
    fft_pkg::bfly_req_t                   req_q;      // captured job
    logic signed [fft_pkg::SAMPLE_W-1:0]  op_x;       // sample operand
    logic signed [fft_pkg::TW_W-1:0]      op_y;       // twiddle operand
    logic signed [fft_pkg::PROD_W-1:0]    prod;       // shared multiplier out
    logic signed [fft_pkg::ACC_W-1:0]     acc_re;     // re*cos - im*sin
    logic signed [fft_pkg::ACC_W-1:0]     acc_im;     // re*sin + im*cos
    logic signed [fft_pkg::ACC_W-1:0]     t_re_full;  // scaled back, full width
    logic signed [fft_pkg::ACC_W-1:0]     t_im_full;
    logic signed [fft_pkg::SAMPLE_W-1:0]  t_re;       // truncated rotated b
    logic signed [fft_pkg::SAMPLE_W-1:0]  t_im;
    fft_pkg::bfly_res_t                   res_comb;   // x0/x1 during COMBINE
    fft_pkg::bfly_res_t                   res_q;      // held result

    // ----------------------------------------------------------------------
    // phase sequencer, start ignored unless idle
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= fft_pkg::IDLE;
        end else begin
            case (phase)
                fft_pkg::IDLE:    if (start) phase <= fft_pkg::P_RC;
                fft_pkg::P_RC:    phase <= fft_pkg::P_IS;
                fft_pkg::P_IS:    phase <= fft_pkg::P_RS;
                fft_pkg::P_RS:    phase <= fft_pkg::P_IC;
                fft_pkg::P_IC:    phase <= fft_pkg::COMBINE;
                fft_pkg::COMBINE: phase <= fft_pkg::IDLE;
                default:          phase <= fft_pkg::IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // operand select for the single multiplier
    // ----------------------------------------------------------------------
    always_comb begin
        op_x = req_q.b.re;                          // P_RC and idle
        op_y = req_q.tw.cos;
        case (phase)
            fft_pkg::P_IS: begin
                op_x = req_q.b.im;
                op_y = req_q.tw.sin;
            end
            fft_pkg::P_RS: begin
                op_x = req_q.b.re;
                op_y = req_q.tw.sin;
            end
            fft_pkg::P_IC: begin
                op_x = req_q.b.im;
                op_y = req_q.tw.cos;
            end
            default: ;
        endcase
    end

    assign prod = op_x * op_y;                      // both signed, full product

    // ----------------------------------------------------------------------
    // job capture, accumulation, result hold
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (phase == fft_pkg::IDLE && start) begin
            req_q <= req;
        end
        case (phase)
            fft_pkg::P_RC:    acc_re <= prod;           // sign extends
            fft_pkg::P_IS:    acc_re <= acc_re - prod;
            fft_pkg::P_RS:    acc_im <= prod;
            fft_pkg::P_IC:    acc_im <= acc_im + prod;
            fft_pkg::COMBINE: res_q  <= res_comb;       // keep for the collector
            default: ;
        endcase
    end

    // truncation: arithmetic shift, no rounding
    assign t_re_full = acc_re >>> fft_pkg::TW_FRAC;
    assign t_im_full = acc_im >>> fft_pkg::TW_FRAC;
    assign t_re      = t_re_full[fft_pkg::SAMPLE_W-1:0];
    assign t_im      = t_im_full[fft_pkg::SAMPLE_W-1:0];

    always_comb begin
        res_comb.x0.re = req_q.a.re + t_re;             // wraps at SAMPLE_W
        res_comb.x0.im = req_q.a.im + t_im;
        res_comb.x1.re = req_q.a.re - t_re;
        res_comb.x1.im = req_q.a.im - t_im;
    end

    assign done = (phase == fft_pkg::COMBINE);          // one cycle per job
    assign res  = done ? res_comb : res_q;              // same value after COMBINE

endmodule

/* hdl/fft_bfly_top.sv */
`timescale 1ns/1ps

module fft_bfly_top #(
    parameter int NUM_LANES = 4             // needs to be 3 or more
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  fft_pkg::cplx_t    in_sample,
    input  fft_pkg::twiddle_t in_tw,
    output logic              out_valid,
    output fft_pkg::cplx_t    out_sample,
    output logic              out_second
);

    fft_pkg::bfly_req_t   req;                      // shared job bus
    logic [NUM_LANES-1:0] lane_start;               // one-hot kick
    logic [NUM_LANES-1:0] lane_done;                // per-lane done strobe
    fft_pkg::bfly_res_t   lane_res [NUM_LANES];     // per-lane result

    // ----------------------------------------------------------------------
    // pairing and dispatch
    // ----------------------------------------------------------------------
    pair_demux #(
        .NUM_LANES (NUM_LANES)
    ) i_demux (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .in_tw     (in_tw),
        .req       (req),
        .start     (lane_start)
    );

    // butterfly lanes, one job each in flight
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        butterfly_lane i_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .start (lane_start[g]),
            .req   (req),
            .done  (lane_done[g]),
            .res   (lane_res[g])
        );
    end

    // back to a single stream
    pair_collector #(
        .NUM_LANES (NUM_LANES)
    ) i_collector (
        .clk        (clk),
        .rst_n      (rst_n),
        .done       (lane_done),
        .res        (lane_res),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .out_second (out_second)
    );

endmodule

/* hdl/fft_pkg.sv */
package fft_pkg;

    // ----------------------------------------------------------------------
    // datapath widths
    // ----------------------------------------------------------------------
    localparam int SAMPLE_W = 16;               // re/im component, two's complement
    localparam int TW_W     = 14;               // cos/sin, Q1.13
    localparam int TW_FRAC  = 13;               // product shift back to sample scale
    localparam int PROD_W   = SAMPLE_W + TW_W;  // full signed partial product
    localparam int ACC_W    = PROD_W + 1;       // guard bit for sum of two products

    // ----------------------------------------------------------------------
    // payload structs
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;         // real part
        logic signed [SAMPLE_W-1:0] im;         // imaginary part
    } cplx_t;

    typedef struct packed {
        logic signed [TW_W-1:0] cos;            // twiddle real part
        logic signed [TW_W-1:0] sin;            // twiddle imaginary part
    } twiddle_t;

    typedef struct packed {
        cplx_t    a;                            // first sample of the pair
        cplx_t    b;                            // second sample, gets rotated
        twiddle_t tw;                           // twiddle that arrived with b
    } bfly_req_t;

    typedef struct packed {
        cplx_t x0;                              // a + b*w
        cplx_t x1;                              // a - b*w
    } bfly_res_t;

    // ----------------------------------------------------------------------
    // state encodings
    // ----------------------------------------------------------------------
    typedef enum logic {
        WAIT_A,                                 // next sample is a
        WAIT_B                                  // next sample is b
    } pair_state_e;

    typedef enum logic [2:0] {
        IDLE,
        P_RC,                                   // re * cos
        P_IS,                                   // im * sin
        P_RS,                                   // re * sin
        P_IC,                                   // im * cos
        COMBINE                                 // shift, add/sub, done
    } mul_phase_e;

endpackage

/* hdl/pair_collector.sv */
`timescale 1ns/1ps

module pair_collector #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LANES-1:0] done,
    input  fft_pkg::bfly_res_t   res [NUM_LANES],
    output logic                 out_valid,
    output fft_pkg::cplx_t       out_sample,
    output logic                 out_second
);

    fft_pkg::bfly_res_t sel_res;        // result of the lane that just finished
    fft_pkg::cplx_t     x1_q;           // x1 parked for the second beat
    logic               any_done;       // some lane finished this cycle
    logic               pend;           // x1 still to be sent

    // ----------------------------------------------------------------------
    // lane select, dones never overlap so priority order is irrelevant
    // ----------------------------------------------------------------------
    always_comb begin
        sel_res = res[0];
        for (int i = 0; i < NUM_LANES; i++) begin
            if (done[i]) begin
                sel_res = res[i];
            end
        end
    end

    assign any_done = |done;

    // ----------------------------------------------------------------------
    // output sequencing, x0 then x1
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_second <= 1'b0;
            pend       <= 1'b0;
        end else if (any_done) begin
            out_valid  <= 1'b1;         // x0 beat
            out_second <= 1'b0;
            pend       <= 1'b1;
        end else if (pend) begin
            out_valid  <= 1'b1;         // x1 beat
            out_second <= 1'b1;
            pend       <= 1'b0;
        end else begin
            out_valid  <= 1'b0;
            out_second <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (any_done) begin
            out_sample <= sel_res.x0;
            x1_q       <= sel_res.x1;
        end else if (pend) begin
            out_sample <= x1_q;
        end
    end

endmodule

/* hdl/pair_demux.sv */
`timescale 1ns/1ps

module pair_demux #(
    parameter int NUM_LANES = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  fft_pkg::cplx_t         in_sample,
    input  fft_pkg::twiddle_t      in_tw,
    output fft_pkg::bfly_req_t     req,
    output logic [NUM_LANES-1:0]   start
);

    // pointer needs at least one bit even for a single lane
    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    fft_pkg::pair_state_e state;            // which half of the pair comes next
    fft_pkg::cplx_t       a_q;              // held a sample
    logic [PTR_W-1:0]     ptr;              // round-robin lane pointer

    // ----------------------------------------------------------------------
    // pairing fsm, lane pointer and start strobe
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fft_pkg::WAIT_A;
            ptr   <= '0;
            start <= '0;
        end else begin
            start <= '0;                    // single-cycle strobe by default
            if (in_valid) begin
                case (state)
                    fft_pkg::WAIT_A: begin
                        state <= fft_pkg::WAIT_B;
                    end
                    fft_pkg::WAIT_B: begin
                        state      <= fft_pkg::WAIT_A;
                        start[ptr] <= 1'b1; // kick the chosen lane
                        if (ptr == PTR_W'(NUM_LANES - 1)) begin
                            ptr <= '0;      // wrap
                        end else begin
                            ptr <= ptr + 1'b1;
                        end
                    end
                    default: state <= fft_pkg::WAIT_A;
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // payload capture
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (state == fft_pkg::WAIT_A) begin
                a_q <= in_sample;           // park a until b shows up
            end else begin
                req.a  <= a_q;
                req.b  <= in_sample;
                req.tw <= in_tw;            // only b's twiddle is kept
            end
        end
    end

    // req is shared by all lanes, only the lane
    // whose start bit is set will pick it up
endmodule
